// File: design/z88_defines.svh
`ifndef Z88_DEFINES_SVH
`define Z88_DEFINES_SVH

// Bus and memory widths
`define Z88_MA_W      22
`define Z88_CA_W      16
`define Z88_ROMRAM_W  19

// clk cycles without a PS/2 clock edge before a frame is dropped
`define Z88_PS2_TIMEOUT  2000

// I/O ports, low address byte
`define Z88_PORT_SR0  8'hD0
`define Z88_PORT_SR1  8'hD1
`define Z88_PORT_SR2  8'hD2
`define Z88_PORT_SR3  8'hD3
`define Z88_PORT_COM  8'hB0
`define Z88_PORT_INT  8'hB1
`define Z88_PORT_STA  8'hB1   // Read side of INT
`define Z88_PORT_KBD  8'hB2
`define Z88_PORT_ACK  8'hB6
`define Z88_PORT_PB0  8'h70
`define Z88_PORT_PB1  8'h71
`define Z88_PORT_PB2  8'h72
`define Z88_PORT_PB3  8'h73
`define Z88_PORT_SBR  8'h74

`endif

// File: design/z88_mem_pkg.sv
`default_nettype none
`include "z88_defines.svh"

package z88_mem_pkg;

  typedef logic [`Z88_CA_W-1:0] cpu_addr_t;
  typedef logic [`Z88_MA_W-1:0] mem_addr_t;
  typedef logic [7:0]           bank_t;
  typedef logic [7:0]           data_t;

  // All strobes active low
  typedef struct packed {
    logic rom_ce_n;
    logic ram_ce_n;
    logic se1_n;
    logic se2_n;
    logic se3_n;
    logic oe_n;
    logic we_n;
  } mem_sel_t;

  // Z80 side of the glue
  typedef struct packed {
    cpu_addr_t addr;
    data_t     wdata;
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
  } cpu_bus_t;

endpackage

`default_nettype wire

// File: design/z88_dev_pkg.sv
`default_nettype none

package z88_dev_pkg;

  typedef logic [63:0] kbmat_t;     // Bit row*8+col, 1 = pressed
  typedef logic [7:0]  scancode_t;
  typedef logic [7:0]  sta_t;       // 7 FLAPOPEN, 2 KEY, 0 TIMER

  typedef struct packed {
    logic [12:0] pb0;
    logic [9:0]  pb1;
    logic [8:0]  pb2;
    logic [10:0] pb3;
    logic [10:0] sbr;
  } scr_regs_t;

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    PARITY,
    STOP
  } ps2_state_e;

  // Octal 1rc means valid, row r, column c
  localparam logic [6:0] KEY_MAP [256] = '{
    8'h3E: 7'o100, 8'h3D: 7'o101, 8'h31: 7'o102, 8'h33: 7'o103, 8'h35: 7'o104,
    8'h36: 7'o105, 8'h5A: 7'o106, 8'h66: 7'o107,
    8'h46: 7'o110, 8'h3C: 7'o111, 8'h32: 7'o112, 8'h34: 7'o113, 8'h2C: 7'o114,
    8'h2E: 7'o115,
    8'h45: 7'o120, 8'h44: 7'o121, 8'h2A: 7'o122, 8'h2B: 7'o123, 8'h2D: 7'o124,
    8'h25: 7'o125,
    8'h4D: 7'o130, 8'h43: 7'o131, 8'h21: 7'o132, 8'h23: 7'o133, 8'h24: 7'o134,
    8'h26: 7'o135,
    8'h4C: 7'o140, 8'h4B: 7'o141, 8'h22: 7'o142, 8'h1B: 7'o143, 8'h1D: 7'o144,
    8'h1E: 7'o145,
    8'h52: 7'o150, 8'h42: 7'o151, 8'h1A: 7'o152, 8'h1C: 7'o153, 8'h15: 7'o154,
    8'h16: 7'o155, 8'h29: 7'o156,
    8'h3A: 7'o161, 8'h3B: 7'o162, 8'h4A: 7'o163, 8'h49: 7'o164, 8'h58: 7'o165,
    8'h12: 7'o166,
    8'h41: 7'o171, 8'h0D: 7'o172, 8'h76: 7'o175, 8'h59: 7'o177,
    default: 7'o000
  };

endpackage

`default_nettype wire

// File: design/blink_bank_map.sv
`timescale 1ns/10ps
`default_nettype none

module blink_bank_map
  import z88_mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cpu_bus_t    bus,
  input  bank_t [3:0] sr,
  output mem_addr_t   ma,
  output mem_sel_t    sel
);

  bank_t bank;
  logic  mem_cyc;
  logic  mem_rd;
  logic  mem_wr;
  logic  we_q_n;

  // Segment picked by the top two address bits
  assign bank = sr[bus.addr[15:14]];
  assign ma   = {bank, bus.addr[13:0]};

  assign mem_cyc = ~bus.mreq_n;
  assign mem_rd  = mem_cyc & ~bus.rd_n;
  assign mem_wr  = mem_cyc & ~bus.wr_n;

  // Write strobe waits a cycle for address and data to settle
  always_ff @(posedge clk) begin
    if (reset) begin
      we_q_n <= 1'b1;
    end else begin
      we_q_n <= ~mem_wr;
    end
  end

  always_comb begin
    sel      = '1;
    sel.oe_n = ~mem_rd;
    sel.we_n = we_q_n | ~mem_wr;   // Ends with the bus cycle
    if (mem_cyc) begin
      case (bank[7:6])
        2'b00: begin
          if (bank[5]) begin
            sel.ram_ce_n = 1'b0;   // 20-3F
          end else begin
            sel.rom_ce_n = 1'b0;   // 00-1F
          end
        end
        2'b01:   sel.se1_n = 1'b0;
        2'b10:   sel.se2_n = 1'b0;
        default: sel.se3_n = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/blink_io_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "z88_defines.svh"

module blink_io_regs
  import z88_mem_pkg::*;
  import z88_dev_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cpu_bus_t    bus,
  input  kbmat_t      kbmat,
  input  logic        flap,
  output bank_t [3:0] sr,
  output data_t       rdata,
  output logic        int_n,
  output logic        lcdon,
  output scr_regs_t   scr
);

  logic [7:0] port;
  logic [7:0] hi;       // Upper address byte, row select and screen high bits
  logic       io_wr;
  data_t      com;
  data_t      int_en;   // 0 GINT, 2 KEY, 7 FLAP
  sta_t       sta_q;
  sta_t       sta_cur;
  sta_t       sta_set;
  sta_t       ack_mask;
  kbmat_t     kbmat_q;
  logic       key_chg;
  logic [1:0] flap_sync;
  logic       flap_last;
  logic       flap_open;
  data_t      kbd_or;

  assign port  = bus.addr[7:0];
  assign hi    = bus.addr[15:8];
  assign io_wr = ~bus.iorq_n & ~bus.wr_n;
  assign lcdon = com[0];

  assign key_chg   = (kbmat != kbmat_q);
  assign flap_open = flap_sync[1] & ~flap_last;

  // KEY shows up in the same cycle the matrix moved
  assign sta_cur  = sta_q | {5'b0, key_chg, 2'b0};
  assign sta_set  = {flap_open, 4'b0, key_chg, 2'b0};
  assign ack_mask = (io_wr && port == `Z88_PORT_ACK) ? bus.wdata : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      sr        <= '0;
      com       <= '0;
      int_en    <= '0;
      sta_q     <= '0;
      scr       <= '0;
      kbmat_q   <= '0;
      flap_sync <= '0;
      flap_last <= 1'b0;
      int_n     <= 1'b1;
    end else begin
      kbmat_q   <= kbmat;
      flap_sync <= {flap_sync[0], flap};
      flap_last <= flap_sync[1];
      sta_q     <= (sta_q & ~ack_mask) | sta_set;   // New events beat ACK
      int_n     <= ~(int_en[0] & |(sta_cur & int_en & 8'h84));
      if (io_wr) begin
        case (port)
          `Z88_PORT_SR0: sr[0] <= bus.wdata;
          `Z88_PORT_SR1: sr[1] <= bus.wdata;
          `Z88_PORT_SR2: sr[2] <= bus.wdata;
          `Z88_PORT_SR3: sr[3] <= bus.wdata;
          `Z88_PORT_COM: com <= bus.wdata;
          `Z88_PORT_INT: int_en <= bus.wdata;
          `Z88_PORT_PB0: scr.pb0 <= {hi[4:0], bus.wdata};
          `Z88_PORT_PB1: scr.pb1 <= {hi[1:0], bus.wdata};
          `Z88_PORT_PB2: scr.pb2 <= {hi[0], bus.wdata};
          `Z88_PORT_PB3: scr.pb3 <= {hi[2:0], bus.wdata};
          `Z88_PORT_SBR: scr.sbr <= {hi[2:0], bus.wdata};
          default: ;
        endcase
      end
    end
  end

  // A row takes part when its address line is low
  always_comb begin
    kbd_or = '0;
    for (int r = 0; r < 8; r++) begin
      if (!hi[r]) begin
        kbd_or = kbd_or | kbmat[r*8 +: 8];
      end
    end
  end

  always_comb begin
    case (port)
      `Z88_PORT_KBD: rdata = ~kbd_or;   // Pressed keys read as 0
      `Z88_PORT_STA: rdata = sta_cur;
      default:       rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ps2_keyboard.sv
`timescale 1ns/10ps
`default_nettype none
`include "z88_defines.svh"

module ps2_keyboard
  import z88_dev_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   ps2clk,
  input  logic   ps2dat,
  output kbmat_t kbmat
);

  localparam int TO_W = $clog2(`Z88_PS2_TIMEOUT + 1);
  localparam logic [TO_W-1:0] TO_LAST = TO_W'(`Z88_PS2_TIMEOUT - 1);

  logic [2:0]      clk_sync;
  logic [1:0]      dat_sync;
  logic            ps2_fall;
  logic            ps2_bit;
  ps2_state_e      state;
  logic [2:0]      bit_cnt;
  logic [TO_W-1:0] idle_cnt;
  scancode_t       shreg;
  logic            par_ok;
  logic            byte_vld;
  logic            release_arm;
  logic [6:0]      map_ent;

  assign ps2_fall = clk_sync[2] & ~clk_sync[1];
  assign ps2_bit  = dat_sync[1];
  assign map_ent  = KEY_MAP[shreg];

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync <= '1;   // Lines idle high
      dat_sync <= '1;
    end else begin
      clk_sync <= {clk_sync[1:0], ps2clk};
      dat_sync <= {dat_sync[0], ps2dat};
    end
  end

  // Frame FSM with inactivity timeout
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      idle_cnt <= '0;
      byte_vld <= 1'b0;
    end else begin
      byte_vld <= 1'b0;
      if (ps2_fall || state == IDLE) begin
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (!ps2_fall && state != IDLE && idle_cnt == TO_LAST) begin
        state <= IDLE;   // Partial frame dropped
      end else if (ps2_fall) begin
        case (state)
          IDLE: begin
            if (!ps2_bit) begin
              state   <= DATA;
              bit_cnt <= '0;
            end
          end
          DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= PARITY;
          end
          PARITY: state <= STOP;
          STOP: begin
            byte_vld <= par_ok & ps2_bit;
            state    <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // LSB first; parity over data plus parity bit must be odd
  always_ff @(posedge clk) begin
    if (ps2_fall && state == DATA) shreg <= {ps2_bit, shreg[7:1]};
    if (ps2_fall && state == PARITY) par_ok <= ^{shreg, ps2_bit};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      kbmat       <= '0;
      release_arm <= 1'b0;
    end else if (byte_vld) begin
      if (shreg == 8'hF0) begin
        release_arm <= 1'b1;
      end else if (shreg != 8'hE0) begin
        release_arm <= 1'b0;   // Consumed even by unmapped codes
        if (map_ent[6]) kbmat[map_ent[5:0]] <= ~release_arm;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/z88_glue.sv
`timescale 1ns/10ps
`default_nettype none
`include "z88_defines.svh"

module z88_glue
  import z88_mem_pkg::*;
  import z88_dev_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     flap,     // 1 while the flap is open
  input  logic                     ps2clk,
  input  logic                     ps2dat,
  input  cpu_addr_t                cpu_addr,
  input  data_t                    cpu_wdata,
  input  logic                     mreq_n,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  output data_t                    cpu_rdata,
  output logic [`Z88_ROMRAM_W-1:0] ram_a,
  output logic [`Z88_ROMRAM_W-1:0] rom_a,
  output data_t                    ram_di,
  input  data_t                    ram_do,
  input  data_t                    rom_do,
  output logic                     ram_ce_n,
  output logic                     ram_oe_n,
  output logic                     ram_we_n,
  output logic                     rom_ce_n,
  output logic                     rom_oe_n,
  output logic                     se1_n,
  output logic                     se2_n,
  output logic                     se3_n,
  output mem_addr_t                slot_a,
  output logic                     int_n,
  output logic                     lcdon,
  output scr_regs_t                scr
);

  cpu_bus_t    bus;
  bank_t [3:0] sr;
  mem_addr_t   ma;
  mem_sel_t    sel;
  kbmat_t      kbmat;
  data_t       io_rdata;

  assign bus = '{addr: cpu_addr, wdata: cpu_wdata, mreq_n: mreq_n,
                 iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n};

  blink_bank_map u_bank_map (.clk(clk), .reset(reset), .bus(bus), .sr(sr),
                             .ma(ma), .sel(sel));

  blink_io_regs u_io_regs (.clk(clk), .reset(reset), .bus(bus), .kbmat(kbmat),
                           .flap(flap), .sr(sr), .rdata(io_rdata), .int_n(int_n),
                           .lcdon(lcdon), .scr(scr));

  ps2_keyboard u_ps2 (.clk(clk), .reset(reset), .ps2clk(ps2clk), .ps2dat(ps2dat),
                      .kbmat(kbmat));

  // On-board chips see the low 512 KB; cards get the full address
  assign ram_a    = ma[`Z88_ROMRAM_W-1:0];
  assign rom_a    = ma[`Z88_ROMRAM_W-1:0];
  assign slot_a   = ma;
  assign ram_di   = cpu_wdata;
  assign ram_ce_n = sel.ram_ce_n;
  assign ram_oe_n = sel.oe_n;
  assign ram_we_n = sel.we_n;
  assign rom_ce_n = sel.rom_ce_n;
  assign rom_oe_n = sel.oe_n;
  assign se1_n    = sel.se1_n;
  assign se2_n    = sel.se2_n;
  assign se3_n    = sel.se3_n;

  always_comb begin
    if (!sel.rom_ce_n && !sel.oe_n) cpu_rdata = rom_do;
    else if (!sel.ram_ce_n && !sel.oe_n) cpu_rdata = ram_do;
    else if (!iorq_n && !rd_n) cpu_rdata = io_rdata;
    else cpu_rdata = 8'hFF;   // Floating bus
  end

endmodule

`default_nettype wire

// File: sim/z88_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "z88_defines.svh"

module z88_checker
  import z88_mem_pkg::*;
  import z88_dev_pkg::*;
(
  input  logic clk, reset, flap, ps2clk, ps2dat,
  input  cpu_addr_t cpu_addr,
  input  data_t cpu_wdata, cpu_rdata, ram_di,
  input  logic mreq_n, iorq_n, rd_n, wr_n,
  input  logic [`Z88_ROMRAM_W-1:0] ram_a, rom_a,
  input  logic ram_ce_n, ram_oe_n, ram_we_n, rom_ce_n, rom_oe_n, se1_n, se2_n, se3_n,
  input  mem_addr_t slot_a,
  input  logic int_n, lcdon,
  input  scr_regs_t scr,
  input  int test_num,
  input  logic done,
  output int errors
);

  bank_t msr [4];
  data_t com, inten, exp_rd, d;
  logic sk, sf, rel, prev_mwr, prev_pclk, prev_flap, mrd, mwr, closed;
  kbmat_t mat, old;
  scr_regs_t mscr;
  data_t mram [int];
  logic [10:0] fr;
  int nbits, idle, idx, cur_test, test_base;
  bank_t bank;
  mem_addr_t ma;
  logic [4:0] ce;
  logic [7:0] hi, port;

  initial errors = 0;

  task automatic expect_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // Row*8+col for the keys the stimulus uses, -1 when unmapped
  function automatic int key_index(input logic [7:0] code);
    case (code)
      8'h3E: return 0;
      8'h5A: return 6;
      8'h2C: return 12;
      8'h25: return 21;
      8'h1D: return 36;
      8'h15: return 44;
      8'h58: return 53;
      8'h59: return 63;
      default: return -1;
    endcase
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      foreach (msr[i]) msr[i] = '0;
      {com, inten, sk, sf, rel, prev_mwr, mat, mscr, nbits, idle} = '0;
      mram.delete();
    end else begin
      bank = msr[cpu_addr[15:14]];
      ma   = {bank, cpu_addr[13:0]};
      hi   = cpu_addr[15:8];
      port = cpu_addr[7:0];
      mrd  = !mreq_n && !rd_n;
      mwr  = !mreq_n && !wr_n;
      ce   = '1;   // rom, ram, se1, se2, se3
      if (!mreq_n) begin
        if (bank < 8'h20) ce[4] = 1'b0;
        else if (bank < 8'h40) ce[3] = 1'b0;
        else if (bank < 8'h80) ce[2] = 1'b0;
        else if (bank < 8'hC0) ce[1] = 1'b0;
        else ce[0] = 1'b0;
        expect_val("slot_a", ma, slot_a);
        expect_val("rom_a", ma[18:0], rom_a);
        expect_val("ram_a", ma[18:0], ram_a);
      end
      if (mwr) expect_val("ram_di", cpu_wdata, ram_di);
      expect_val("chip selects", ce, {rom_ce_n, ram_ce_n, se1_n, se2_n, se3_n});
      expect_val("rom_oe_n", !mrd, rom_oe_n);
      expect_val("ram_oe_n", !mrd, ram_oe_n);
      expect_val("ram_we_n", !(mwr && prev_mwr), ram_we_n);

      exp_rd = 8'hFF;
      if (mrd && !ce[4]) exp_rd = ma[7:0] ^ ma[15:8] ^ {5'b0, ma[18:16]};
      if (mrd && !ce[3]) begin
        exp_rd = mram.exists(ma[18:0]) ? mram[ma[18:0]]
                 : ma[7:0] + ma[15:8] + {5'b0, ma[18:16]};
      end
      if (!iorq_n && !rd_n) begin
        exp_rd = 8'h00;
        if (port == `Z88_PORT_STA) exp_rd = {sf, 4'b0, sk, 2'b0};
        if (port == `Z88_PORT_KBD) begin
          for (int r = 0; r < 8; r++) begin
            if (!hi[r]) exp_rd = exp_rd | mat[r*8 +: 8];
          end
          exp_rd = ~exp_rd;
        end
        expect_val("int_n", !(inten[0] && ((sk && inten[2]) || (sf && inten[7]))), int_n);
        expect_val("lcdon", com[0], lcdon);
        expect_val("scr", mscr, scr);
      end
      expect_val("cpu_rdata", exp_rd, cpu_rdata);

      if (mwr && !ce[3]) mram[ma[18:0]] = cpu_wdata;
      if (!iorq_n && !wr_n) begin
        d = cpu_wdata;
        case (port)
          8'hD0, 8'hD1, 8'hD2, 8'hD3: msr[port[1:0]] = d;
          `Z88_PORT_COM: com = d;
          `Z88_PORT_INT: inten = d;
          `Z88_PORT_ACK: {sf, sk} = {sf & ~d[7], sk & ~d[2]};
          `Z88_PORT_PB0: mscr.pb0 = {hi[4:0], d};
          `Z88_PORT_PB1: mscr.pb1 = {hi[1:0], d};
          `Z88_PORT_PB2: mscr.pb2 = {hi[0], d};
          `Z88_PORT_PB3: mscr.pb3 = {hi[2:0], d};
          `Z88_PORT_SBR: mscr.sbr = {hi[2:0], d};
          default: ;
        endcase
      end
      if (flap && !prev_flap) sf = 1'b1;

      // PS/2 frame model, bits sampled on the falling clock
      if (prev_pclk && !ps2clk) begin
        fr = {ps2dat, fr[10:1]};
        idle = 0;
        nbits = (nbits == 0 && ps2dat) ? 0 : nbits + 1;
        if (nbits == 11) begin
          nbits = 0;
          if (^fr[9:1] && fr[10]) begin
            if (fr[8:1] == 8'hF0) begin
              rel = 1'b1;
            end else if (fr[8:1] != 8'hE0) begin
              idx = key_index(fr[8:1]);
              old = mat;
              if (idx >= 0) mat[idx] = ~rel;
              if (mat != old) sk = 1'b1;
              rel = 1'b0;
            end
          end
        end
      end else if (nbits > 0) begin
        idle++;
        if (idle >= `Z88_PS2_TIMEOUT) nbits = 0;   // Partial frame dropped
      end
      prev_mwr = mwr;
    end
    prev_pclk = ps2clk;
    prev_flap = flap;
  end

  always @(posedge clk) begin
    if (test_num != cur_test || (done && !closed)) begin
      if (cur_test > 0) $display("Test %0d finished with %0d errors", cur_test,
                                 errors - test_base);
      cur_test  = test_num;
      test_base = errors;
      if (done) begin
        closed = 1'b1;
        $display("Checks done: %0d errors in %0d tests", errors, test_num);
      end
    end
  end

  initial begin
    cur_test = 0;
    test_base = 0;
    closed = 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/tb_z88.sv
`timescale 1ns/10ps
`default_nettype none
`include "z88_defines.svh"

module tb_z88
  import z88_mem_pkg::*;
  import z88_dev_pkg::*;
;

  localparam int MAX_CYCLES = 6 * 12000 + 2000;   // Six tests, worst one is the keyboard matrix

  logic clk, reset, flap, ps2clk, ps2dat;
  logic mreq_n, iorq_n, rd_n, wr_n;
  cpu_addr_t cpu_addr;
  data_t cpu_wdata, cpu_rdata, ram_di, ram_do, rom_do;
  logic [`Z88_ROMRAM_W-1:0] ram_a, rom_a;
  logic ram_ce_n, ram_oe_n, ram_we_n, rom_ce_n, rom_oe_n, se1_n, se2_n, se3_n;
  mem_addr_t slot_a;
  logic int_n, lcdon;
  scr_regs_t scr;
  int test_num;
  logic done;
  int errors;
  int cycles;
  logic [7:0] rom [0:2**`Z88_ROMRAM_W-1];
  logic [7:0] ram [0:2**`Z88_ROMRAM_W-1];
  logic [7:0] codes [12] = '{8'h3E, 8'h5A, 8'h2C, 8'h25, 8'h1D, 8'h15, 8'h58, 8'h59,
                             8'h05, 8'h06, 8'h0C, 8'hE0};

  z88_glue DUT (.*);

  z88_checker chk (.*);

  assign rom_do = rom[rom_a];
  assign ram_do = ram[ram_a];

  always @(posedge clk) begin
    if (!ram_ce_n && !ram_we_n) ram[ram_a] <= ram_di;
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Run stopped because the cycle limit was reached");
      $display("Something failed");
      $finish;
    end
  end

  // One bus cycle, hold is the number of edges it is seen on
  task automatic bus_cycle(input logic io, input logic wr, input logic [15:0] a,
                           input logic [7:0] d, input int hold);
    @(posedge clk);
    cpu_addr  <= a;
    cpu_wdata <= d;
    mreq_n    <= io;
    iorq_n    <= ~io;
    rd_n      <= wr;
    wr_n      <= ~wr;
    repeat (hold) @(posedge clk);
    {mreq_n, iorq_n, rd_n, wr_n} <= 4'hF;
  endtask

  // Start, 8 data LSB first, odd parity, stop; cut > 0 stops after that many bits
  task automatic send_frame(input logic [7:0] code, input bit bad_par, input bit bad_stop,
                            input int cut);
    logic [10:0] bits;
    int n;
    bits = {~bad_stop, ~^code ^ bad_par, code, 1'b0};
    n = (cut > 0) ? cut : 11;
    for (int i = 0; i < n; i++) begin
      @(posedge clk) ps2dat <= bits[i];
      repeat (4) @(posedge clk);
      ps2clk <= 1'b0;
      repeat (4) @(posedge clk);
      ps2clk <= 1'b1;
    end
    @(posedge clk) ps2dat <= 1'b1;
    repeat ((cut > 0) ? `Z88_PS2_TIMEOUT + 200 : 20) @(posedge clk);
  endtask

  task automatic key_event(input logic [7:0] code, input bit brk);
    if (brk) send_frame(8'hF0, 0, 0, 0);
    send_frame(code, 0, 0, 0);
  endtask

  initial begin
    void'($urandom(32'h6530_046a));
    for (int i = 0; i < 2**`Z88_ROMRAM_W; i++) begin
      rom[i] = i[7:0] ^ i[15:8] ^ {5'b0, i[18:16]};   // Content follows the address
      ram[i] = i[7:0] + i[15:8] + {5'b0, i[18:16]};
    end
    {reset, flap, ps2clk, ps2dat} = 4'b1011;
    {mreq_n, iorq_n, rd_n, wr_n} = 4'hF;
    cpu_addr = '0;
    cpu_wdata = '0;
    test_num = 0;
    done = 1'b0;
    cycles = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    test_num <= 1;   // Reset state
    bus_cycle(1, 0, 16'h0000, 0, 1);
    bus_cycle(0, 0, 16'($urandom & 16'h3FFF), 0, 1);

    test_num <= 2;   // Banking
    for (int i = 0; i < 30; i++) begin
      bus_cycle(1, 1, {8'h00, 8'hD0 + 8'($urandom % 4)}, 8'($urandom), 1);
      bus_cycle(0, $urandom % 2, 16'($urandom), 8'($urandom), 2);
    end

    test_num <= 3;   // Keyboard matrix
    for (int i = 0; i < 40; i++) begin
      key_event(codes[$urandom % 12], $urandom % 2);
      bus_cycle(1, 0, {8'($urandom), `Z88_PORT_KBD}, 0, 1);
    end
    for (int k = 0; k < 8; k++) key_event(codes[k], 1);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_KBD}, 0, 1);

    test_num <= 4;   // Broken frames
    send_frame(8'h3E, 1, 0, 0);
    send_frame(8'h5A, 0, 1, 0);
    send_frame(8'h59, 0, 0, 5);
    send_frame(8'h15, 0, 0, 9);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_KBD}, 0, 1);
    key_event(8'h3E, 0);   // Receiver back in step after the cut frames
    bus_cycle(1, 0, {8'h00, `Z88_PORT_KBD}, 0, 1);
    key_event(8'h3E, 1);

    test_num <= 5;   // Interrupts
    bus_cycle(1, 1, {8'h00, `Z88_PORT_INT}, 8'h85, 1);
    bus_cycle(1, 1, {8'h00, `Z88_PORT_ACK}, 8'hFF, 1);
    key_event(8'h5A, 0);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_STA}, 0, 1);
    bus_cycle(1, 1, {8'h00, `Z88_PORT_ACK}, 8'h04, 1);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_STA}, 0, 1);
    flap <= 1'b1;
    repeat (10) @(posedge clk);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_STA}, 0, 1);
    bus_cycle(1, 1, {8'h00, `Z88_PORT_ACK}, 8'h80, 1);
    bus_cycle(1, 0, {8'h00, `Z88_PORT_STA}, 0, 1);
    flap <= 1'b0;

    test_num <= 6;   // COM and screen registers
    for (int i = 0; i < 20; i++) begin
      bus_cycle(1, 1, {8'($urandom), ($urandom % 6 == 0) ? `Z88_PORT_COM
                       : 8'h70 + 8'($urandom % 5)}, 8'($urandom), 1);
      bus_cycle(1, 0, 16'h0000, 0, 1);
    end

    repeat (2) @(posedge clk);
    done <= 1'b1;
    repeat (2) @(posedge clk);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/z88_mem_pkg.sv
design/z88_dev_pkg.sv
design/blink_bank_map.sv
design/blink_io_regs.sv
design/ps2_keyboard.sv
design/z88_glue.sv
sim/z88_checker.sv
sim/tb_z88.sv

// File: Bender.yml
package:
  name: z88_glue

sources:
  - include_dirs:
      - design
    files:
      - design/z88_mem_pkg.sv
      - design/z88_dev_pkg.sv
      - design/blink_bank_map.sv
      - design/blink_io_regs.sv
      - design/ps2_keyboard.sv
      - design/z88_glue.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/z88_checker.sv
      - sim/tb_z88.sv
